// ==== verilog/mul_consts.svh ====
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// operand and result word width
`define MUL_DATA_W 32

// width of the 64-bit accumulator that holds rm*rs + {rh,rn}
`define MUL_ACC_W 64

// width of one operand half, one guard bit above 16 for the sign
`define MUL_PART_W 17

// op field layout
`define MUL_OP_W 4
`define MUL_OP_HI 0
`define MUL_OP_SIGNED 1
`define MUL_OP_ACC 2
`define MUL_OP_VALID 3

// shift amounts for the cross and high partial products
`define MUL_SH_MID 16
`define MUL_SH_HI 32

`endif

// ==== verilog/mul_pkg.sv ====
`include "mul_consts.svh"

package mul_pkg;

        // decoded form of the op field, the valid bit is consumed by decode
        typedef struct packed {
                logic hi_sel;
                logic is_signed;
                logic accumulate;
        } mul_op_t;

        // the accumulator split into its two result words
        typedef struct packed {
                logic [`MUL_DATA_W-1:0] hi;
                logic [`MUL_DATA_W-1:0] lo;
        } mul_halves_t;

        // one 64-bit word, seen either as the running signed sum
        // or as the hi and lo words that writeback chooses between
        typedef union packed {
                logic signed [`MUL_ACC_W-1:0] sum;
                mul_halves_t                  half;
        } mul_acc_u;

endpackage

// ==== verilog/mul_issue_if.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

// decoded operation and operands handed from decode to the accumulator
interface mul_issue_if;

        logic                   start;
        mul_pkg::mul_op_t       op;
        logic [`MUL_DATA_W-1:0] rm;
        logic [`MUL_DATA_W-1:0] rs;
        logic [`MUL_DATA_W-1:0] rn;
        logic [`MUL_DATA_W-1:0] rh;

        modport decode (
                output start,
                output op,
                output rm,
                output rs,
                output rn,
                output rh
        );

        // op and operands stay stable until the next accepted issue
        modport mac (
                input start,
                input op,
                input rm,
                input rs,
                input rn,
                input rh
        );

endinterface

// ==== verilog/mul_issue_decode.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_issue_decode (
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  logic                   i_issue,
        input  logic [`MUL_OP_W-1:0]   i_op,
        input  logic                   i_cc_pass,
        input  logic [`MUL_DATA_W-1:0] i_rm,
        input  logic [`MUL_DATA_W-1:0] i_rs,
        input  logic [`MUL_DATA_W-1:0] i_rn,
        input  logic [`MUL_DATA_W-1:0] i_rh,
        input  logic                   i_flush,
        input  logic                   i_mac_busy,
        output logic                   o_busy,
        mul_issue_if.decode            o_iss
);

        logic             pending_q;
        logic             accept;
        mul_pkg::mul_op_t op_dec;

        // a failed condition or a non-multiply op is simply dropped here
        assign accept = i_issue && !o_busy && i_op[`MUL_OP_VALID] && i_cc_pass;

        // pending covers the cycle before the accumulator leaves idle
        assign o_busy = pending_q || i_mac_busy;

        always_comb
        begin
                op_dec.hi_sel     = i_op[`MUL_OP_HI];
                op_dec.is_signed  = i_op[`MUL_OP_SIGNED];
                op_dec.accumulate = i_op[`MUL_OP_ACC];
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_iss.start <= 1'b0;
                        pending_q   <= 1'b0;
                end
                else if (i_flush)
                begin
                        o_iss.start <= 1'b0;
                        pending_q   <= 1'b0;
                end
                else
                begin
                        o_iss.start <= accept;
                        if (accept)
                                pending_q <= 1'b1;
                        else if (i_mac_busy)
                                pending_q <= 1'b0;
                end
        end

        // the accumulator reads these live, so they only change on a new issue
        always_ff @(posedge i_clk)
        begin
                if (accept && !i_flush)
                begin
                        o_iss.op <= op_dec;
                        o_iss.rm <= i_rm;
                        o_iss.rs <= i_rs;
                        o_iss.rn <= i_rn;
                        o_iss.rh <= i_rh;
                end
        end

endmodule

// ==== verilog/mul_partial_mac.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_partial_mac (
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  logic                   i_stall,
        input  logic                   i_flush,
        mul_issue_if.mac               i_iss,
        output logic                   o_busy,
        output logic                   o_done,
        output mul_pkg::mul_acc_u      o_sum,
        output logic                   o_hi_sel
);

        localparam int EXT_W = `MUL_ACC_W - `MUL_PART_W;

        typedef enum logic [2:0] {
                ST_IDLE,
                ST_S1,
                ST_S2,
                ST_S3,
                ST_S4,
                ST_S5
        } state_t;

        state_t            state_q;
        state_t            state_d;
        mul_pkg::mul_acc_u acc_d;
        logic              start_hold_q;
        logic              go;

        // a = rm high, b = rs high, c = rm low, d = rs low
        logic signed [`MUL_PART_W-1:0] a;
        logic signed [`MUL_PART_W-1:0] b;
        logic signed [`MUL_PART_W-1:0] c;
        logic signed [`MUL_PART_W-1:0] d;
        logic signed [`MUL_ACC_W-1:0]  a_x;
        logic signed [`MUL_ACC_W-1:0]  b_x;
        logic signed [`MUL_ACC_W-1:0]  c_x;
        logic signed [`MUL_ACC_W-1:0]  d_x;
        logic signed [`MUL_ACC_W-1:0]  ab;
        logic signed [`MUL_ACC_W-1:0]  ad;
        logic signed [`MUL_ACC_W-1:0]  bc;
        logic signed [`MUL_ACC_W-1:0]  cd;

        // only the upper halves carry the operand sign
        assign a = i_iss.op.is_signed ? {i_iss.rm[31], i_iss.rm[31:16]} : {1'b0, i_iss.rm[31:16]};
        assign b = i_iss.op.is_signed ? {i_iss.rs[31], i_iss.rs[31:16]} : {1'b0, i_iss.rs[31:16]};
        assign c = {1'b0, i_iss.rm[15:0]};
        assign d = {1'b0, i_iss.rs[15:0]};

        assign a_x = {{EXT_W{a[`MUL_PART_W-1]}}, a};
        assign b_x = {{EXT_W{b[`MUL_PART_W-1]}}, b};
        assign c_x = {{EXT_W{c[`MUL_PART_W-1]}}, c};
        assign d_x = {{EXT_W{d[`MUL_PART_W-1]}}, d};

        assign ab = a_x * b_x;
        assign ad = a_x * d_x;
        assign bc = b_x * c_x;
        assign cd = c_x * d_x;

        // a start that arrives during a stall is kept in start_hold_q
        assign go = i_iss.start || start_hold_q;

        assign o_busy = (state_q != ST_IDLE);
        assign o_done = (state_q == ST_S5) && !i_stall;

        always_comb
        begin
                state_d = state_q;
                acc_d   = o_sum;

                case (state_q)
                ST_IDLE:
                begin
                        if (go)
                        begin
                                state_d = ST_S1;
                                if (i_iss.op.accumulate)
                                        acc_d.sum = {i_iss.rh, i_iss.rn};
                                else
                                        acc_d.sum = '0;
                        end
                end
                ST_S1:
                begin
                        state_d   = ST_S2;
                        acc_d.sum = o_sum.sum + cd;
                end
                ST_S2:
                begin
                        state_d   = ST_S3;
                        acc_d.sum = o_sum.sum + (ab <<< `MUL_SH_HI);
                end
                ST_S3:
                begin
                        state_d   = ST_S4;
                        acc_d.sum = o_sum.sum + (ad <<< `MUL_SH_MID);
                end
                ST_S4:
                begin
                        state_d   = ST_S5;
                        acc_d.sum = o_sum.sum + (bc <<< `MUL_SH_MID);
                end
                ST_S5:
                begin
                        // sum is final, writeback samples it this cycle
                        state_d = ST_IDLE;
                end
                default:
                begin
                        state_d = ST_IDLE;
                end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        state_q      <= ST_IDLE;
                        o_sum.sum    <= '0;
                        start_hold_q <= 1'b0;
                end
                else if (i_stall)
                begin
                        if (state_q == ST_IDLE && i_iss.start)
                                start_hold_q <= 1'b1;
                end
                else
                begin
                        state_q      <= state_d;
                        o_sum        <= acc_d;
                        start_hold_q <= 1'b0;
                end
        end

        // hi_sel travels with done so writeback needs no view of the op
        always_ff @(posedge i_clk)
        begin
                if (state_q == ST_IDLE && go && !i_stall)
                        o_hi_sel <= i_iss.op.hi_sel;
        end

endmodule

// ==== verilog/mul_result_select.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_result_select (
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  logic                   i_flush,
        input  logic                   i_done,
        input  mul_pkg::mul_acc_u      i_sum,
        input  logic                   i_hi_sel,
        output logic                   o_result_valid,
        output logic [`MUL_DATA_W-1:0] o_rd,
        output logic                   o_flag_n,
        output logic                   o_flag_z
);

        logic [`MUL_DATA_W-1:0] sel_word;

        // the halves view of the sum gives the two candidate words
        assign sel_word = i_hi_sel ? i_sum.half.hi : i_sum.half.lo;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_result_valid <= 1'b0;
                        o_rd           <= '0;
                        o_flag_n       <= 1'b0;
                        o_flag_z       <= 1'b0;
                end
                else if (i_flush)
                begin
                        // an abandoned operation never reaches the result
                        o_result_valid <= 1'b0;
                end
                else
                begin
                        o_result_valid <= i_done;
                        if (i_done)
                        begin
                                o_rd     <= sel_word;
                                o_flag_n <= sel_word[`MUL_DATA_W-1];
                                o_flag_z <= (sel_word == '0);
                        end
                end
        end

endmodule

// ==== verilog/mul_unit_top.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_unit_top (
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  logic                   i_issue,
        input  logic [`MUL_OP_W-1:0]   i_op,
        input  logic                   i_cc_pass,
        input  logic [`MUL_DATA_W-1:0] i_rm,
        input  logic [`MUL_DATA_W-1:0] i_rs,
        input  logic [`MUL_DATA_W-1:0] i_rn,
        input  logic [`MUL_DATA_W-1:0] i_rh,
        input  logic                   i_stall,
        input  logic                   i_flush,
        output logic                   o_busy,
        output logic                   o_result_valid,
        output logic [`MUL_DATA_W-1:0] o_rd,
        output logic                   o_flag_n,
        output logic                   o_flag_z
);

        mul_issue_if       iss ();

        logic              mac_busy;
        logic              mac_done;
        mul_pkg::mul_acc_u mac_sum;
        logic              mac_hi_sel;

        mul_issue_decode u_decode (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_issue    (i_issue),
                .i_op       (i_op),
                .i_cc_pass  (i_cc_pass),
                .i_rm       (i_rm),
                .i_rs       (i_rs),
                .i_rn       (i_rn),
                .i_rh       (i_rh),
                .i_flush    (i_flush),
                .i_mac_busy (mac_busy),
                .o_busy     (o_busy),
                .o_iss      (iss)
        );

        // stall reaches only the accumulator
        mul_partial_mac u_mac (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_stall  (i_stall),
                .i_flush  (i_flush),
                .i_iss    (iss),
                .o_busy   (mac_busy),
                .o_done   (mac_done),
                .o_sum    (mac_sum),
                .o_hi_sel (mac_hi_sel)
        );

        mul_result_select u_select (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_done         (mac_done),
                .i_sum          (mac_sum),
                .i_hi_sel       (mac_hi_sel),
                .o_result_valid (o_result_valid),
                .o_rd           (o_rd),
                .o_flag_n       (o_flag_n),
                .o_flag_z       (o_flag_z)
        );

endmodule

// ==== bench/tb_mul_unit.sv ====
`timescale 1ns/1ps
`include "mul_consts.svh"

module tb_mul_unit;

        localparam int IDLE_TIMEOUT   = 40;
        localparam int RESULT_TIMEOUT = 40;
        localparam int QUIET_CYCLES   = 10;
        localparam int BASE_LATENCY   = 6;

        logic                   i_clk;
        logic                   i_reset;
        logic                   i_issue;
        logic [`MUL_OP_W-1:0]   i_op;
        logic                   i_cc_pass;
        logic [`MUL_DATA_W-1:0] i_rm;
        logic [`MUL_DATA_W-1:0] i_rs;
        logic [`MUL_DATA_W-1:0] i_rn;
        logic [`MUL_DATA_W-1:0] i_rh;
        logic                   i_stall;
        logic                   i_flush;
        logic                   o_busy;
        logic                   o_result_valid;
        logic [`MUL_DATA_W-1:0] o_rd;
        logic                   o_flag_n;
        logic                   o_flag_z;

        // one golden line, every field read as a hex word
        logic [31:0] f_kind;
        logic [31:0] f_op;
        logic [31:0] f_cc;
        logic [31:0] f_rm;
        logic [31:0] f_rs;
        logic [31:0] f_rn;
        logic [31:0] f_rh;
        logic [31:0] f_rd;
        logic [31:0] f_n;
        logic [31:0] f_z;
        logic [31:0] f_res;

        logic [31:0]      rng_state;
        logic [8*160-1:0] line_buf;
        int               fd;
        int               got;
        int               line_no;
        int               op_count;

        mul_unit_top uut (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_issue        (i_issue),
                .i_op           (i_op),
                .i_cc_pass      (i_cc_pass),
                .i_rm           (i_rm),
                .i_rs           (i_rs),
                .i_rn           (i_rn),
                .i_rh           (i_rh),
                .i_stall        (i_stall),
                .i_flush        (i_flush),
                .o_busy         (o_busy),
                .o_result_valid (o_result_valid),
                .o_rd           (o_rd),
                .o_flag_n       (o_flag_n),
                .o_flag_z       (o_flag_z)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #10 i_clk = ~i_clk;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        task automatic fail_run;
                $display("Done: errors found");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_value(input logic [31:0] seen, input logic [31:0] want,
                                   input string what);
                if (seen !== want)
                begin
                        $display("FAILED at %0t ns: line %0d %s is %h, expected %h",
                                 $time, line_no, what, seen, want);
                        fail_run();
                end
        endtask

        // outputs are sampled and inputs driven 1 ns after the rising edge
        task automatic next_cycle;
                @(posedge i_clk);
                #1;
        endtask

        // nothing may come out of the unit for the whole window
        task automatic expect_quiet;
                repeat (QUIET_CYCLES)
                begin
                        next_cycle();
                        check_value({31'd0, o_result_valid}, 32'd0, "o_result_valid");
                        check_value({31'd0, o_busy}, 32'd0, "o_busy");
                end
        endtask

        task automatic run_line;
                int   waited;
                int   elapsed;
                int   stalls;
                logic accepted;
                logic use_stall;
                logic seen_result;
                waited = 0;
                while (o_busy)
                begin
                        next_cycle();
                        waited++;
                        if (waited > IDLE_TIMEOUT)
                        begin
                                $display("timeout: o_busy never dropped before line %0d", line_no);
                                fail_run();
                        end
                end
                accepted  = f_op[`MUL_OP_VALID] && f_cc[0];
                i_issue   = 1'b1;
                i_op      = f_op[`MUL_OP_W-1:0];
                i_cc_pass = f_cc[0];
                i_rm      = f_rm;
                i_rs      = f_rs;
                i_rn      = f_rn;
                i_rh      = f_rh;
                next_cycle();
                i_issue = 1'b0;
                // the previous result strobe must already be gone
                check_value({31'd0, o_result_valid}, 32'd0, "o_result_valid at issue");
                check_value({31'd0, o_busy}, {31'd0, accepted}, "o_busy after issue");
                if (f_kind == 32'd1)
                begin
                        // flush is sampled at the third edge after the issue edge
                        next_cycle();
                        next_cycle();
                        i_flush = 1'b1;
                        next_cycle();
                        i_flush = 1'b0;
                        check_value({31'd0, o_busy}, 32'd0, "o_busy after flush");
                        expect_quiet();
                end
                else if (!f_res[0])
                begin
                        expect_quiet();
                end
                else
                begin
                        elapsed     = 0;
                        stalls      = 0;
                        seen_result = 1'b0;
                        while (!seen_result)
                        begin
                                use_stall = 1'b0;
                                if (f_kind == 32'd2)
                                begin
                                        rng_state = xorshift32(rng_state);
                                        use_stall = (rng_state[1:0] == 2'b00);
                                end
                                i_stall = use_stall;
                                if (use_stall)
                                        stalls++;
                                next_cycle();
                                elapsed++;
                                if (o_result_valid)
                                        seen_result = 1'b1;
                                else if (elapsed > RESULT_TIMEOUT)
                                begin
                                        $display("timeout: no result strobe for line %0d", line_no);
                                        fail_run();
                                end
                        end
                        i_stall = 1'b0;
                        check_value(elapsed, BASE_LATENCY + stalls, "result latency");
                        check_value({31'd0, o_busy}, 32'd0, "o_busy with result");
                        check_value(o_rd, f_rd, "o_rd");
                        check_value({31'd0, o_flag_n}, f_n, "o_flag_n");
                        check_value({31'd0, o_flag_z}, f_z, "o_flag_z");
                end
        endtask

        initial
        begin
                i_reset   = 1'b1;
                i_issue   = 1'b0;
                i_op      = '0;
                i_cc_pass = 1'b0;
                i_rm      = '0;
                i_rs      = '0;
                i_rn      = '0;
                i_rh      = '0;
                i_stall   = 1'b0;
                i_flush   = 1'b0;
                rng_state = 32'h7aae_ab30;
                line_no   = 0;
                op_count  = 0;
                repeat (2) next_cycle();
                i_reset = 1'b0;
                next_cycle();
                fd = $fopen("bench/mul_golden.txt", "r");
                if (fd == 0)
                begin
                        $display("could not open bench/mul_golden.txt");
                        fail_run();
                end
                while (!$feof(fd))
                begin
                        got = $fgets(line_buf, fd);
                        line_no++;
                        // comment and blank lines do not scan as eleven fields
                        if (got > 0 && $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h",
                                               f_kind, f_op, f_cc, f_rm, f_rs, f_rn, f_rh,
                                               f_rd, f_n, f_z, f_res) == 11)
                        begin
                                op_count++;
                                run_line();
                        end
                end
                $fclose(fd);
                next_cycle();
                check_value({31'd0, o_result_valid}, 32'd0, "o_result_valid after last result");
                if (op_count == 0)
                begin
                        $display("the golden file held no operations");
                        fail_run();
                end
                else
                begin
                        $display("Done: no errors");
                        $finish;
                end
        end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/mul_pkg.sv
verilog/mul_issue_if.sv
verilog/mul_issue_decode.sv
verilog/mul_partial_mac.sv
verilog/mul_result_select.sv
verilog/mul_unit_top.sv
bench/tb_mul_unit.sv

// ==== Makefile ====
# Verilator build and run of the multiply unit testbench

BIN  := obj_dir/Vtb_mul_unit
SRCS := compile.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_mul_unit \
		-f compile.f -o Vtb_mul_unit

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log

check: run
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/mul_golden.txt ====
# kind (0 op, 1 flush test, 2 op with random stalls), op, cc_pass, rm, rs, rn, rh
# then expected rd, N, Z and 1 when a result is expected
0 8 1 00000003 00000005 deadbeef 12345678 0000000f 0 0 1
0 9 1 00000003 00000005 00000000 00000000 00000000 0 1 1
0 8 1 ffffffff ffffffff 00000000 00000000 00000001 0 0 1
0 9 1 ffffffff ffffffff 00000000 00000000 fffffffe 1 0 1
0 8 1 80000000 00000002 00000000 00000000 00000000 0 1 1
0 9 1 80000000 00000002 00000000 00000000 00000001 0 0 1
0 8 1 00010001 00010001 00000000 00000000 00020001 0 0 1
0 9 1 00010001 00010001 00000000 00000000 00000001 0 0 1
0 8 1 abcd0000 00000010 00000000 00000000 bcd00000 1 0 1
0 a 1 ffffffff 00000005 00000000 00000000 fffffffb 1 0 1
0 b 1 ffffffff 00000005 00000000 00000000 ffffffff 1 0 1
0 a 1 fffffffe fffffffd 00000000 00000000 00000006 0 0 1
0 b 1 fffffffe fffffffd 00000000 00000000 00000000 0 1 1
0 b 1 80000000 80000000 00000000 00000000 40000000 0 0 1
0 a 1 00000000 fffffff0 00000000 00000000 00000000 0 1 1
0 b 1 ffffffff ffffffff 00000000 00000000 00000000 0 1 1
0 a 1 ffff8000 00007fff 00000000 00000000 c0008000 1 0 1
0 b 1 fffe0003 00020001 00000000 00000000 fffffffc 1 0 1
0 a 1 fffe0003 00020001 00000000 00000000 00040003 0 0 1
0 9 1 fffe0003 00020001 00000000 00000000 0001fffd 0 0 1
0 c 1 00000002 00000003 00000010 00000000 00000016 0 0 1
0 d 1 ffffffff 00000001 00000001 00000005 00000006 0 0 1
0 d 1 ffffffff ffffffff ffffffff 00000001 00000000 0 1 1
0 e 1 fffffffd 00000004 00000010 00000000 00000004 0 0 1
0 f 1 ffffffff 00000001 00000000 00000002 00000001 0 0 1
0 e 1 ffffffff 00000001 00000000 00000002 ffffffff 1 0 1
0 f 1 80000000 7fffffff 80000000 10000000 d0000001 1 0 1
0 e 1 80000000 7fffffff 80000000 10000000 00000000 0 1 1
0 8 0 00000003 00000005 00000000 00000000 00000000 0 0 0
0 1 1 00000003 00000005 00000000 00000000 00000000 0 0 0
0 7 1 00000003 00000005 00000000 00000000 00000000 0 0 0
1 9 1 ffffffff ffffffff 00000000 00000000 00000000 0 0 0
0 9 1 ffffffff ffffffff 00000000 00000000 fffffffe 1 0 1
1 f 1 80000000 7fffffff 80000000 10000000 00000000 0 0 0
0 e 1 fffffffd 00000004 00000010 00000000 00000004 0 0 1
2 9 1 ffffffff ffffffff 00000000 00000000 fffffffe 1 0 1
2 8 1 00030002 00050004 00000000 00000000 00160008 0 0 1
2 9 1 00030002 00050004 00000000 00000000 0000000f 0 0 1
2 b 1 fffe0003 00020001 00000000 00000000 fffffffc 1 0 1
2 f 1 80000000 7fffffff 80000000 10000000 d0000001 1 0 1
2 a 1 ffff8000 00007fff 00000000 00000000 c0008000 1 0 1
